/* Bender.yml */
package:
  name: mps_system

sources:
  - files:
      - design/mps_pkg.sv
      - design/mps_axil_regs.sv
      - design/mps_intl_monitor.sv
      - design/mps_system_fsm.sv
      - design/mps_op_fsm.sv
      - design/mps_system_top.sv
  - target: test
    files:
      - verif/mps_checker.sv
      - verif/mps_tb.sv

export_include_dirs: []

dependencies: {}

/* design/mps_axil_regs.sv */
module mps_axil_regs #(
	parameter int P_DATA_W = 32,
	parameter int P_ADDR_W = 5
)(
	input  logic                    i_clk,
	input  logic                    i_rst,

	input  logic [P_ADDR_W-1:0]     i_awaddr,
	input  logic                    i_awvalid,
	output logic                    o_awready,
	input  logic [P_DATA_W-1:0]     i_wdata,
	input  logic [P_DATA_W/8-1:0]   i_wstrb,
	input  logic                    i_wvalid,
	output logic                    o_wready,
	output logic [1:0]              o_bresp,
	output logic                    o_bvalid,
	input  logic                    i_bready,

	input  logic [P_ADDR_W-1:0]     i_araddr,
	input  logic                    i_arvalid,
	output logic                    o_arready,
	output logic [P_DATA_W-1:0]     o_rdata,
	output logic [1:0]              o_rresp,
	output logic                    o_rvalid,
	input  logic                    i_rready,

	output mps_pkg::mps_cmd_t       o_cmd,
	output logic [4:0]              o_do,
	output logic [31:0]             o_dc_v_min,

	input  mps_pkg::sys_state_e     i_mode,
	input  logic                    i_pwm_en,
	input  mps_pkg::op_status_t     i_op,
	input  mps_pkg::intl_status_t   i_intl,
	input  logic [15:0]             i_ext_di
);

	localparam int IDX_W = $clog2(mps_pkg::REG_NUM);

	logic [IDX_W-1:0]      wr_idx;
	logic [IDX_W-1:0]      rd_idx;
	logic                  wr_en;
	logic                  rd_en;
	logic [3:0]            fail_code_q;
	mps_pkg::status_reg_t  status;
	logic [P_DATA_W-1:0]   rd_mux;

	assign wr_idx = i_awaddr[IDX_W+1:2];
	assign rd_idx = i_araddr[IDX_W+1:2];
	assign wr_en = o_awready && i_awvalid && i_wvalid;
	assign rd_en = o_arready && i_arvalid;

	assign o_bresp = 2'b00;  // always OKAY
	assign o_rresp = 2'b00;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write channel

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_awready <= 1'b0;
			o_wready <= 1'b0;
			o_bvalid <= 1'b0;
		end
		else
		begin
			// address and data are taken together, never while a response waits
			o_awready <= !o_awready && i_awvalid && i_wvalid && !o_bvalid;
			o_wready <= !o_awready && i_awvalid && i_wvalid && !o_bvalid;
			if (wr_en)
				o_bvalid <= 1'b1;
			else if (i_bready)
				o_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_cmd <= '0;
			o_do <= '0;
			o_dc_v_min <= '0;
		end
		else
		begin
			o_cmd <= '0;  // strobes last a single cycle
			if (wr_en && wr_idx == IDX_W'(mps_pkg::REG_CMD) && i_wstrb[0])
				o_cmd <= mps_pkg::mps_cmd_t'(i_wdata[4:0]);
			if (wr_en && wr_idx == IDX_W'(mps_pkg::REG_DO) && i_wstrb[0])
				o_do <= i_wdata[mps_pkg::DO_W-1:0];
			if (wr_en && wr_idx == IDX_W'(mps_pkg::REG_DC_V_MIN))
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (i_wstrb[b])
						o_dc_v_min[8*b +: 8] <= i_wdata[8*b +: 8];
				end
			end
		end
	end

	// the last failure stays readable until software starts a new on sequence
	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
			fail_code_q <= '0;
		else if (o_cmd.op_on)
			fail_code_q <= '0;
		else if (i_op.fail)
			fail_code_q <= i_op.fail_code;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read channel

	always_comb
	begin
		status = '0;
		status.mode = i_mode;
		status.op_state = i_op.state;
		status.fail_code = fail_code_q;
		status.pwm_en = i_pwm_en;

		case (rd_idx)
			IDX_W'(mps_pkg::REG_DO):         rd_mux = P_DATA_W'(o_do);
			IDX_W'(mps_pkg::REG_DC_V_MIN):   rd_mux = P_DATA_W'(o_dc_v_min);
			IDX_W'(mps_pkg::REG_STATUS):     rd_mux = P_DATA_W'(status);
			IDX_W'(mps_pkg::REG_INTL):       rd_mux = P_DATA_W'(i_intl.latched);
			IDX_W'(mps_pkg::REG_INTL_FIRST): rd_mux = P_DATA_W'(i_intl.first);
			IDX_W'(mps_pkg::REG_DI):         rd_mux = P_DATA_W'(i_ext_di);
			default:                         rd_mux = '0;  // REG_CMD reads as zero
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			o_arready <= 1'b0;
			o_rvalid <= 1'b0;
		end
		else
		begin
			o_arready <= !o_arready && i_arvalid && !o_rvalid;
			if (rd_en)
				o_rvalid <= 1'b1;
			else if (i_rready)
				o_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (rd_en)
			o_rdata <= rd_mux;  // held while rvalid waits
	end

endmodule

/* design/mps_intl_monitor.sv */
module mps_intl_monitor (
	input  logic                   i_clk,
	input  logic                   i_rst,
	input  logic [17:0]            i_analog_intl,
	input  logic [15:0]            i_ext_di,
	input  logic                   i_clr,
	output mps_pkg::intl_status_t  o_intl
);

	logic [mps_pkg::INTL_W-1:0] src;
	logic [mps_pkg::INTL_W-1:0] latched;
	logic [mps_pkg::INTL_W-1:0] first;
	logic                       flag;
	logic                       clr_ok;

	assign src = {i_ext_di[8:4], i_ext_di[0], i_analog_intl};
	assign clr_ok = i_clr && !(|src);  // a live source blocks the clear

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			flag <= 1'b0;
			latched <= '0;
			first <= '0;
		end
		else
		begin
			flag <= |src;
			if (clr_ok)
			begin
				latched <= '0;
				first <= '0;
			end
			else
			begin
				latched <= latched | src;
				if (latched == '0 && src != '0)
					first <= src;  // snapshot of the sources that tripped first
			end
		end
	end

	assign o_intl = {flag, latched, first};

endmodule

/* design/mps_op_fsm.sv */
module mps_op_fsm #(
	parameter int P_SEQ_TIMEOUT = 1000
)(
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_on_start,
	input  logic                 i_off_start,
	input  logic                 i_intl_flag,
	input  logic [31:0]          i_dc_v,
	input  logic [31:0]          i_dc_v_min,
	input  logic                 i_mc_fb,
	output logic [2:0]           o_mc,
	output mps_pkg::op_status_t  o_op
);

	localparam int CNT_W = $clog2(P_SEQ_TIMEOUT + 1);

	mps_pkg::op_state_e state;
	mps_pkg::op_state_e state_nxt;
	logic [CNT_W-1:0]   cnt;
	logic               waiting;
	logic               timeout;
	logic               fail_nxt;
	logic [3:0]         code_nxt;
	logic               on_done;
	logic               off_done;
	logic               fail;
	logic [3:0]         fail_code;

	assign waiting = (state == mps_pkg::OP_MC_CLOSE) || (state == mps_pkg::OP_DC_WAIT)
		|| (state == mps_pkg::OP_MC_OPEN);
	assign timeout = (cnt == CNT_W'(P_SEQ_TIMEOUT - 1));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state

	always_comb
	begin
		state_nxt = state;
		fail_nxt = 1'b0;
		code_nxt = '0;
		case (state)
			mps_pkg::OP_IDLE:
				if (i_on_start && !i_intl_flag)
					state_nxt = mps_pkg::OP_MC_CLOSE;
			mps_pkg::OP_MC_CLOSE:
				if (i_mc_fb)
					state_nxt = mps_pkg::OP_DC_WAIT;
				else if (timeout)
				begin
					state_nxt = mps_pkg::OP_ON_FAIL;
					fail_nxt = 1'b1;
					code_nxt[mps_pkg::FAIL_MC_FB] = 1'b1;
				end
			mps_pkg::OP_DC_WAIT:
				if (i_dc_v >= i_dc_v_min)
					state_nxt = mps_pkg::OP_ON_DONE;
				else if (timeout)
				begin
					state_nxt = mps_pkg::OP_ON_FAIL;
					fail_nxt = 1'b1;
					code_nxt[mps_pkg::FAIL_DC_V] = 1'b1;
				end
			mps_pkg::OP_ON_DONE:
				if (i_off_start)
					state_nxt = mps_pkg::OP_MC_OPEN;
			mps_pkg::OP_MC_OPEN:
				if (!i_mc_fb)
					state_nxt = mps_pkg::OP_OFF_DONE;
				else if (timeout)
				begin
					// still report off_done so the system side leaves OFF_SEQ
					state_nxt = mps_pkg::OP_OFF_DONE;
					fail_nxt = 1'b1;
					code_nxt[mps_pkg::FAIL_MC_OPEN] = 1'b1;
				end
			default:
				state_nxt = mps_pkg::OP_IDLE;  // ON_FAIL and OFF_DONE last one cycle
		endcase

		if (i_intl_flag && ((state == mps_pkg::OP_MC_CLOSE) || (state == mps_pkg::OP_DC_WAIT)
			|| (state == mps_pkg::OP_ON_DONE)))
		begin
			state_nxt = mps_pkg::OP_MC_OPEN;
			fail_nxt = 1'b0;
			code_nxt = '0;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// registered outputs

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			state <= mps_pkg::OP_IDLE;
			cnt <= '0;
			on_done <= 1'b0;
			off_done <= 1'b0;
			fail <= 1'b0;
			fail_code <= '0;
			o_mc <= '0;
		end
		else
		begin
			state <= state_nxt;
			if (state_nxt != state || !waiting)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			on_done <= (state_nxt == mps_pkg::OP_ON_DONE) && (state != mps_pkg::OP_ON_DONE);
			off_done <= (state_nxt == mps_pkg::OP_OFF_DONE);
			fail <= fail_nxt;
			if (fail_nxt)
				fail_code <= code_nxt;
			else if (i_on_start)
				fail_code <= '0;

			// mc bits are {fan, precharge, main}
			case (state_nxt)
				mps_pkg::OP_MC_CLOSE, mps_pkg::OP_DC_WAIT: o_mc <= 3'b111;
				mps_pkg::OP_ON_DONE:                       o_mc <= 3'b101;  // precharge drops out
				default:                                   o_mc <= 3'b000;
			endcase
		end
	end

	always_comb
	begin
		o_op.state = state;
		o_op.on_done = on_done;
		o_op.off_done = off_done;
		o_op.fail = fail;
		o_op.fail_code = fail_code;
	end

endmodule

/* design/mps_pkg.sv */
package mps_pkg;

	// system operating mode, encoding is visible to software through REG_STATUS
	typedef enum logic [2:0] {
		OFF     = 3'd0,
		ON_SEQ  = 3'd1,
		READY   = 3'd2,
		RUN     = 3'd3,
		OFF_SEQ = 3'd4,
		INTL    = 3'd5
	} sys_state_e;

	typedef enum logic [3:0] {
		OP_IDLE     = 4'd0,
		OP_MC_CLOSE = 4'd1,
		OP_DC_WAIT  = 4'd2,
		OP_ON_DONE  = 4'd3,
		OP_ON_FAIL  = 4'd4,
		OP_MC_OPEN  = 4'd5,
		OP_OFF_DONE = 4'd6
	} op_state_e;

	// field order follows the REG_CMD bits, op_on sits in bit 0
	typedef struct packed {
		logic intl_clr;
		logic ready;
		logic run;
		logic op_off;
		logic op_on;
	} mps_cmd_t;

	typedef struct packed {
		op_state_e  state;
		logic       on_done;
		logic       off_done;
		logic       fail;
		logic [3:0] fail_code;
	} op_status_t;

	localparam int unsigned FAIL_MC_FB   = 0;  // contactor feedback never arrived
	localparam int unsigned FAIL_DC_V    = 1;  // dc link stayed below the minimum
	localparam int unsigned FAIL_MC_OPEN = 2;  // feedback stuck high on opening

	// latched bit order is analog[17:0], then ext_di[0], then ext_di[8:4]
	localparam int unsigned INTL_W = 24;

	typedef struct packed {
		logic              flag;
		logic [INTL_W-1:0] latched;
		logic [INTL_W-1:0] first;
	} intl_status_t;

	localparam int unsigned REG_CMD        = 0;
	localparam int unsigned REG_DO         = 1;
	localparam int unsigned REG_DC_V_MIN   = 2;
	localparam int unsigned REG_STATUS     = 3;
	localparam int unsigned REG_INTL       = 4;
	localparam int unsigned REG_INTL_FIRST = 5;
	localparam int unsigned REG_DI         = 6;
	localparam int unsigned REG_NUM        = 7;

	localparam int unsigned DO_W = 5;

	// REG_STATUS word: mode [2:0], op state [7:4], fail_code [11:8], pwm_en [12]
	typedef struct packed {
		logic [18:0] rsvd;
		logic        pwm_en;
		logic [3:0]  fail_code;
		op_state_e   op_state;
		logic        pad;
		sys_state_e  mode;
	} status_reg_t;

endpackage

/* design/mps_system_fsm.sv */
module mps_system_fsm (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  mps_pkg::mps_cmd_t    i_cmd,
	input  logic                 i_intl_flag,
	input  mps_pkg::op_status_t  i_op,
	output mps_pkg::sys_state_e  o_mode,
	output logic                 o_pwm_en,
	output logic                 o_on_start,
	output logic                 o_off_start,
	output logic                 o_dc_v_under_intl_en
);

	mps_pkg::sys_state_e state;
	mps_pkg::sys_state_e state_nxt;

	always_comb
	begin
		state_nxt = state;
		case (state)
			mps_pkg::OFF:
				if (i_cmd.op_on)
					state_nxt = mps_pkg::ON_SEQ;
			mps_pkg::ON_SEQ:
				if (i_op.on_done)
					state_nxt = mps_pkg::READY;
				else if (i_op.fail)
					state_nxt = mps_pkg::OFF;
			mps_pkg::READY:
				if (i_cmd.op_off)
					state_nxt = mps_pkg::OFF_SEQ;
				else if (i_cmd.run)
					state_nxt = mps_pkg::RUN;
			mps_pkg::RUN:
				if (i_cmd.op_off)
					state_nxt = mps_pkg::OFF_SEQ;
				else if (i_cmd.ready)
					state_nxt = mps_pkg::READY;
			mps_pkg::OFF_SEQ:
				if (i_op.off_done)
					state_nxt = mps_pkg::OFF;
			mps_pkg::INTL:
				if (i_cmd.intl_clr && !i_intl_flag)
					state_nxt = mps_pkg::OFF;
			default:
				state_nxt = mps_pkg::OFF;
		endcase

		// an interlock overrides every other event
		if (i_intl_flag)
			state_nxt = mps_pkg::INTL;
	end

	always_ff @(posedge i_clk or negedge i_rst)
	begin
		if (!i_rst)
		begin
			state <= mps_pkg::OFF;
			o_on_start <= 1'b0;
			o_off_start <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			o_on_start <= (state == mps_pkg::OFF) && (state_nxt == mps_pkg::ON_SEQ);
			o_off_start <= (state != mps_pkg::OFF_SEQ) && (state_nxt == mps_pkg::OFF_SEQ);
		end
	end

	// the flag drops pwm one cycle ahead of the INTL state
	assign o_pwm_en = (state == mps_pkg::RUN) && !i_intl_flag;
	assign o_mode = state;
	assign o_dc_v_under_intl_en = (state == mps_pkg::READY) || (state == mps_pkg::RUN);

endmodule

/* design/mps_system_top.sv */
module mps_system_top #(
	parameter int P_DATA_W = 32,
	parameter int P_ADDR_W = 5,
	parameter int P_SEQ_TIMEOUT = 1000
)(
	input  logic                   i_clk,
	input  logic                   i_rst,

	input  logic [17:0]            i_analog_intl,
	input  logic [31:0]            i_dc_v,
	input  logic [15:0]            i_ext_di,

	input  logic [P_ADDR_W-1:0]    i_s_axi_awaddr,
	input  logic                   i_s_axi_awvalid,
	output logic                   o_s_axi_awready,
	input  logic [P_DATA_W-1:0]    i_s_axi_wdata,
	input  logic [P_DATA_W/8-1:0]  i_s_axi_wstrb,
	input  logic                   i_s_axi_wvalid,
	output logic                   o_s_axi_wready,
	output logic [1:0]             o_s_axi_bresp,
	output logic                   o_s_axi_bvalid,
	input  logic                   i_s_axi_bready,
	input  logic [P_ADDR_W-1:0]    i_s_axi_araddr,
	input  logic                   i_s_axi_arvalid,
	output logic                   o_s_axi_arready,
	output logic [P_DATA_W-1:0]    o_s_axi_rdata,
	output logic [1:0]             o_s_axi_rresp,
	output logic                   o_s_axi_rvalid,
	input  logic                   i_s_axi_rready,

	output logic                   o_pwm_en,
	output logic [7:0]             o_ext_do,
	output mps_pkg::sys_state_e    o_mps_fsm_m,
	output mps_pkg::op_state_e     o_op_state,
	output logic                   o_dc_v_under_intl_en
);

	mps_pkg::mps_cmd_t      cmd;
	mps_pkg::intl_status_t  intl;
	mps_pkg::op_status_t    op;
	logic [4:0]             do_bits;
	logic [31:0]            dc_v_min;
	logic                   on_start;
	logic                   off_start;
	logic [2:0]             mc;

	mps_axil_regs #(
		.P_DATA_W (P_DATA_W),
		.P_ADDR_W (P_ADDR_W)
	) u_regs (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_awaddr   (i_s_axi_awaddr),
		.i_awvalid  (i_s_axi_awvalid),
		.o_awready  (o_s_axi_awready),
		.i_wdata    (i_s_axi_wdata),
		.i_wstrb    (i_s_axi_wstrb),
		.i_wvalid   (i_s_axi_wvalid),
		.o_wready   (o_s_axi_wready),
		.o_bresp    (o_s_axi_bresp),
		.o_bvalid   (o_s_axi_bvalid),
		.i_bready   (i_s_axi_bready),
		.i_araddr   (i_s_axi_araddr),
		.i_arvalid  (i_s_axi_arvalid),
		.o_arready  (o_s_axi_arready),
		.o_rdata    (o_s_axi_rdata),
		.o_rresp    (o_s_axi_rresp),
		.o_rvalid   (o_s_axi_rvalid),
		.i_rready   (i_s_axi_rready),
		.o_cmd      (cmd),
		.o_do       (do_bits),
		.o_dc_v_min (dc_v_min),
		.i_mode     (o_mps_fsm_m),
		.i_pwm_en   (o_pwm_en),
		.i_op       (op),
		.i_intl     (intl),
		.i_ext_di   (i_ext_di)
	);

	mps_intl_monitor u_intl (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_analog_intl (i_analog_intl),
		.i_ext_di      (i_ext_di),
		.i_clr         (cmd.intl_clr),
		.o_intl        (intl)
	);

	mps_system_fsm u_sys_fsm (
		.i_clk                (i_clk),
		.i_rst                (i_rst),
		.i_cmd                (cmd),
		.i_intl_flag          (intl.flag),
		.i_op                 (op),
		.o_mode               (o_mps_fsm_m),
		.o_pwm_en             (o_pwm_en),
		.o_on_start           (on_start),
		.o_off_start          (off_start),
		.o_dc_v_under_intl_en (o_dc_v_under_intl_en)
	);

	// ext_di[1] carries the main contactor auxiliary contact
	mps_op_fsm #(
		.P_SEQ_TIMEOUT (P_SEQ_TIMEOUT)
	) u_op_fsm (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_on_start  (on_start),
		.i_off_start (off_start),
		.i_intl_flag (intl.flag),
		.i_dc_v      (i_dc_v),
		.i_dc_v_min  (dc_v_min),
		.i_mc_fb     (i_ext_di[1]),
		.o_mc        (mc),
		.o_op        (op)
	);

	assign o_ext_do = {do_bits, mc};
	assign o_op_state = op.state;

endmodule

/* verif/mps_checker.sv */
module mps_checker (
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_pwm_en,
	input  mps_pkg::sys_state_e  i_mode,
	input  logic [17:0]          i_analog_intl,
	input  logic [15:0]          i_ext_di,
	input  logic [2:0]           i_mc,
	input  logic                 i_bvalid,
	input  logic                 i_bready,
	input  logic                 i_rvalid,
	input  logic                 i_rready,
	input  logic [31:0]          i_rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_cnt = 0;  // read by the testbench for its closing line
	logic        src_active;

	assign src_active = |{i_ext_di[8:4], i_ext_di[0], i_analog_intl};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	pwm_only_in_run: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_pwm_en |-> (i_mode == mps_pkg::RUN))
	else
	begin
		$error("pwm_en is high outside RUN, mode %s", i_mode.name());
		fail_cnt++;
	end

	// the interlock flag is one register away from the sources
	intl_kills_pwm: assert property (@(posedge i_clk) disable iff (!i_rst)
		src_active |-> ##[0:2] !i_pwm_en)
	else
	begin
		$error("pwm_en still high two cycles after an interlock source");
		fail_cnt++;
	end

	bvalid_holds: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_bvalid && !i_bready) |=> i_bvalid)
	else
	begin
		$error("bvalid dropped before bready");
		fail_cnt++;
	end

	rvalid_holds: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_rvalid && !i_rready) |=> (i_rvalid && $stable(i_rdata)))
	else
	begin
		$error("rvalid dropped or rdata changed before rready");
		fail_cnt++;
	end

	// OFF is entered after an off sequence, an interlock or a failed on sequence
	mc_open_in_off: assert property (@(posedge i_clk) disable iff (!i_rst)
		(i_mode == mps_pkg::OFF
			&& $past(i_mode) inside {mps_pkg::OFF_SEQ, mps_pkg::INTL, mps_pkg::ON_SEQ})
		|=> (i_mc == 3'b000))
	else
	begin
		$error("contactor outputs not open after entering OFF");
		fail_cnt++;
	end

endmodule

bind mps_system_top mps_checker u_chk (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_pwm_en      (o_pwm_en),
	.i_mode        (o_mps_fsm_m),
	.i_analog_intl (i_analog_intl),
	.i_ext_di      (i_ext_di),
	.i_mc          (mc),
	.i_bvalid      (o_s_axi_bvalid),
	.i_bready      (i_s_axi_bready),
	.i_rvalid      (o_s_axi_rvalid),
	.i_rready      (i_s_axi_rready),
	.i_rdata       (o_s_axi_rdata)
);

/* verif/mps_tb.sv */
module mps_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int AXI_TMO = 50;
	localparam int MODE_TMO = 300;
	localparam int MC_DELAY = 6;

	logic                clk = 1'b0;
	logic                rst;
	logic [17:0]         analog_intl;
	logic [31:0]         dc_v;
	logic [15:0]         ext_di;
	logic                mc_fb = 1'b0;
	logic                mc_model_en = 1'b1;
	int                  mc_dly = 0;

	logic [4:0]          awaddr;
	logic                awvalid;
	logic [31:0]         wdata;
	logic [3:0]          wstrb;
	logic                wvalid;
	logic                bready;
	logic [4:0]          araddr;
	logic                arvalid;
	logic                rready;
	logic                o_s_axi_awready;
	logic                o_s_axi_wready;
	logic [1:0]          o_s_axi_bresp;
	logic                o_s_axi_bvalid;
	logic                o_s_axi_arready;
	logic [31:0]         o_s_axi_rdata;
	logic [1:0]          o_s_axi_rresp;
	logic                o_s_axi_rvalid;
	logic                o_pwm_en;
	logic [7:0]          o_ext_do;
	mps_pkg::sys_state_e o_mps_fsm_m;
	mps_pkg::op_state_e  o_op_state;
	logic                o_dc_v_under_intl_en;

	int                  seed = 82823;
	int unsigned         value_errs = 0;
	int unsigned         timeout_errs = 0;
	int unsigned         total_errs;
	logic [31:0]         rd_data;
	logic [31:0]         do_val;
	logic [31:0]         vmin_val;
	int unsigned         intl_bit;

	always #5 clk = ~clk;

	assign ext_di = {14'h0, mc_fb, 1'b0};  // di[1] is the main contactor feedback

	mps_system_top #(
		.P_SEQ_TIMEOUT (64)
	) i_mps_system_top (
		.i_clk                (clk),
		.i_rst                (rst),
		.i_analog_intl        (analog_intl),
		.i_dc_v               (dc_v),
		.i_ext_di             (ext_di),
		.i_s_axi_awaddr       (awaddr),
		.i_s_axi_awvalid      (awvalid),
		.o_s_axi_awready      (o_s_axi_awready),
		.i_s_axi_wdata        (wdata),
		.i_s_axi_wstrb        (wstrb),
		.i_s_axi_wvalid       (wvalid),
		.o_s_axi_wready       (o_s_axi_wready),
		.o_s_axi_bresp        (o_s_axi_bresp),
		.o_s_axi_bvalid       (o_s_axi_bvalid),
		.i_s_axi_bready       (bready),
		.i_s_axi_araddr       (araddr),
		.i_s_axi_arvalid      (arvalid),
		.o_s_axi_arready      (o_s_axi_arready),
		.o_s_axi_rdata        (o_s_axi_rdata),
		.o_s_axi_rresp        (o_s_axi_rresp),
		.o_s_axi_rvalid       (o_s_axi_rvalid),
		.i_s_axi_rready       (rready),
		.o_pwm_en             (o_pwm_en),
		.o_ext_do             (o_ext_do),
		.o_mps_fsm_m          (o_mps_fsm_m),
		.o_op_state           (o_op_state),
		.o_dc_v_under_intl_en (o_dc_v_under_intl_en)
	);

	// contactor model, the aux contact follows the main coil a few cycles late
	always @(negedge clk)
	begin
		if (!rst || !mc_model_en)
		begin
			mc_fb <= 1'b0;
			mc_dly <= 0;
		end
		else if (mc_fb != o_ext_do[0])
		begin
			if (mc_dly == MC_DELAY - 1)
			begin
				mc_fb <= o_ext_do[0];
				mc_dly <= 0;
			end
			else
				mc_dly <= mc_dly + 1;
		end
		else
			mc_dly <= 0;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic wait_mode(input mps_pkg::sys_state_e m);
		int t;
		t = 0;
		while (o_mps_fsm_m !== m && t < MODE_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (o_mps_fsm_m !== m)
		begin
			$display("timeout waiting for mode %s, mode stuck at %s", m.name(),
				o_mps_fsm_m.name());
			timeout_errs++;
		end
	endtask

	task automatic write_reg(input int unsigned idx, input logic [31:0] data);
		int t;
		t = 0;
		@(negedge clk);
		awaddr = 5'(idx << 2);
		wdata = data;
		wstrb = 4'hf;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (!o_s_axi_awready && t < AXI_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (!o_s_axi_awready)
		begin
			$display("timeout: write to register %0d was never accepted", idx);
			timeout_errs++;
		end
		else
			check_value("o_s_axi_wready", {31'h0, o_s_axi_wready}, 32'h1);
		@(negedge clk);  // the handshake took place on the edge just passed
		awvalid = 1'b0;
		wvalid = 1'b0;
		t = 0;
		while (!o_s_axi_bvalid && t < AXI_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (!o_s_axi_bvalid)
		begin
			$display("timeout: no write response for register %0d", idx);
			timeout_errs++;
		end
		else
			check_value("o_s_axi_bresp", {30'h0, o_s_axi_bresp}, 32'h0);
		idle_cycles(2);  // response waits under back-pressure
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input int unsigned idx, output logic [31:0] data);
		int t;
		t = 0;
		data = '0;
		@(negedge clk);
		araddr = 5'(idx << 2);
		arvalid = 1'b1;
		while (!o_s_axi_arready && t < AXI_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (!o_s_axi_arready)
		begin
			$display("timeout: read of register %0d was never accepted", idx);
			timeout_errs++;
		end
		@(negedge clk);
		arvalid = 1'b0;
		t = 0;
		while (!o_s_axi_rvalid && t < AXI_TMO)
		begin
			@(negedge clk);
			t++;
		end
		if (!o_s_axi_rvalid)
		begin
			$display("timeout: no read data for register %0d", idx);
			timeout_errs++;
		end
		else
		begin
			check_value("o_s_axi_rresp", {30'h0, o_s_axi_rresp}, 32'h0);
			idle_cycles(2);
			data = o_s_axi_rdata;
			rready = 1'b1;
			@(negedge clk);
			rready = 1'b0;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		rst = 1'b0;
		analog_intl = '0;
		dc_v = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		idle_cycles(2);

		// register read-back and do pins
		do_val = $random(seed);
		vmin_val = $random(seed);
		write_reg(mps_pkg::REG_DO, do_val);
		read_reg(mps_pkg::REG_DO, rd_data);
		check_value("REG_DO", rd_data, {27'h0, do_val[4:0]});
		check_value("o_ext_do[7:3]", {27'h0, o_ext_do[7:3]}, {27'h0, do_val[4:0]});
		write_reg(mps_pkg::REG_DC_V_MIN, vmin_val);
		read_reg(mps_pkg::REG_DC_V_MIN, rd_data);
		check_value("REG_DC_V_MIN", rd_data, vmin_val);
		write_reg(mps_pkg::REG_DC_V_MIN, 32'h0000_1000);

		// on sequence without contactor feedback, status bits [11:8] hold fail_code
		mc_model_en = 1'b0;
		dc_v = 32'h0000_2000;
		write_reg(mps_pkg::REG_CMD, 32'h01);
		wait_mode(mps_pkg::ON_SEQ);
		wait_mode(mps_pkg::OFF);
		read_reg(mps_pkg::REG_STATUS, rd_data);
		check_value("REG_STATUS.fail_code", {28'h0, rd_data[11:8]}, 32'h1);
		check_value("o_ext_do[2:0]", {29'h0, o_ext_do[2:0]}, 32'h0);

		mc_model_en = 1'b1;
		dc_v = 32'h0000_0100;  // dc link never charges
		write_reg(mps_pkg::REG_CMD, 32'h01);
		wait_mode(mps_pkg::ON_SEQ);
		wait_mode(mps_pkg::OFF);
		read_reg(mps_pkg::REG_STATUS, rd_data);
		check_value("REG_STATUS.fail_code", {28'h0, rd_data[11:8]}, 32'h2);
		check_value("o_ext_do[2:0]", {29'h0, o_ext_do[2:0]}, 32'h0);

		// normal power-on, run and back to ready
		dc_v = 32'h0000_2000;
		write_reg(mps_pkg::REG_CMD, 32'h01);
		wait_mode(mps_pkg::READY);
		check_value("o_dc_v_under_intl_en", {31'h0, o_dc_v_under_intl_en}, 32'h1);
		check_value("o_op_state", {28'h0, o_op_state}, {28'h0, mps_pkg::OP_ON_DONE});
		write_reg(mps_pkg::REG_CMD, 32'h04);
		wait_mode(mps_pkg::RUN);
		check_value("o_pwm_en", {31'h0, o_pwm_en}, 32'h1);
		write_reg(mps_pkg::REG_CMD, 32'h08);
		wait_mode(mps_pkg::READY);
		check_value("o_pwm_en", {31'h0, o_pwm_en}, 32'h0);

		// power-off from RUN
		write_reg(mps_pkg::REG_CMD, 32'h04);
		wait_mode(mps_pkg::RUN);
		write_reg(mps_pkg::REG_CMD, 32'h02);
		wait_mode(mps_pkg::OFF_SEQ);
		wait_mode(mps_pkg::OFF);
		check_value("o_ext_do[2:0]", {29'h0, o_ext_do[2:0]}, 32'h0);
		check_value("o_op_state", {28'h0, o_op_state}, {28'h0, mps_pkg::OP_IDLE});

		// analog interlock during RUN
		write_reg(mps_pkg::REG_CMD, 32'h01);
		wait_mode(mps_pkg::READY);
		write_reg(mps_pkg::REG_CMD, 32'h04);
		wait_mode(mps_pkg::RUN);
		intl_bit = $unsigned($random(seed)) % 18;
		@(negedge clk);
		analog_intl = 18'(1) << intl_bit;
		wait_mode(mps_pkg::INTL);
		check_value("o_pwm_en", {31'h0, o_pwm_en}, 32'h0);
		read_reg(mps_pkg::REG_INTL, rd_data);
		check_value("REG_INTL", rd_data, 32'(1) << intl_bit);
		read_reg(mps_pkg::REG_INTL_FIRST, rd_data);
		check_value("REG_INTL_FIRST", rd_data, 32'(1) << intl_bit);
		write_reg(mps_pkg::REG_CMD, 32'h10);
		idle_cycles(3);
		check_value("o_mps_fsm_m", {29'h0, o_mps_fsm_m}, {29'h0, mps_pkg::INTL});
		analog_intl = '0;
		write_reg(mps_pkg::REG_CMD, 32'h10);
		wait_mode(mps_pkg::OFF);
		read_reg(mps_pkg::REG_INTL, rd_data);
		check_value("REG_INTL", rd_data, 32'h0);

		idle_cycles(4);
		total_errs = value_errs + timeout_errs + i_mps_system_top.u_chk.fail_cnt;
		$display("result: %0d value errors, %0d timeouts, %0d assertion failures",
			value_errs, timeout_errs, i_mps_system_top.u_chk.fail_cnt);
		if (total_errs == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		#200us;
		$display("simulation did not finish in time, stopped by the watchdog");
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* vlog.f */
design/mps_pkg.sv
design/mps_axil_regs.sv
design/mps_intl_monitor.sv
design/mps_system_fsm.sv
design/mps_op_fsm.sv
design/mps_system_top.sv
verif/mps_checker.sv
verif/mps_tb.sv
